/* design/pdp8_ac_pkg.sv */
/*
 * Shared types and constants for the PDP-8/e accumulator datapath.
 * Words use PDP-8 bit numbering, bit 0 is the most significant.
 * Only EAE mode A multiply is supported, with no divide, shifts or NMI.
 */
package pdp8_ac_pkg;

    typedef logic [0:11] word_t;

    // datapath phases, driven each cycle by the external major-state sequencer
    typedef enum logic [3:0] {
        ph_idle      = 4'd0,
        ph_f1        = 4'd1,   // operate sub-phases
        ph_f2        = 4'd2,
        ph_f3        = 4'd3,
        ph_e1        = 4'd4,   // memory reference execute
        ph_e2        = 4'd5,
        ph_e3        = 4'd6,
        ph_eae_start = 4'd7,   // multiply setup
        ph_eae_step  = 4'd8,   // one multiply iteration
        ph_h2        = 4'd9    // console halt
    } phase_t;

    localparam logic [0:2] opc_and = 3'd0;
    localparam logic [0:2] opc_tad = 3'd1;
    localparam logic [0:2] opc_dca = 3'd3;

    localparam int unsigned mul_steps = 12;   // one step per multiplier bit
    typedef logic [$clog2(mul_steps + 1) - 1:0] step_t;

    localparam word_t op_group1      = 12'o7000;   // only bits 0-3 compared
    localparam word_t op_group3_mask = 12'o7401;   // bits 0-3 and 11 all set
    localparam word_t op_mul         = 12'o7405;   // bits 0-3 and 8-11 compared

endpackage

/* design/ac_update_if.sv */
/*
 * Proposed register writes from one execution unit.
 * A strobe high loads the matching value at the next rising edge.
 */
`timescale 1ns/1ps

interface ac_update_if import pdp8_ac_pkg::*;;

    logic  wr_ac;
    logic  wr_link;
    logic  wr_mq;
    word_t ac_next;
    word_t mq_next;
    logic  link_next;

    modport source (output wr_ac, wr_link, wr_mq, ac_next, mq_next, link_next);

    modport sink (input wr_ac, wr_link, wr_mq, ac_next, mq_next, link_next);

endinterface

/* design/operate_unit.sv */
/*
 * Group 1 and group 3 operate microinstructions, purely combinational.
 * Group 2 (skips, OSR, HLT) is not decoded here.
 * Group 3 EAE bits are ignored apart from what MUL needs elsewhere.
 */
`timescale 1ns/1ps

module operate_unit import pdp8_ac_pkg::*;
(
    input  phase_t             phase,
    input  word_t              instruction,
    input  word_t              ac,
    input  logic               link,
    input  word_t              mq,
    ac_update_if.source        upd
);

    logic        is_group1;
    logic        is_group3;
    word_t       f1_ac;
    logic        f1_link;
    logic [0:12] inc_sum;
    logic [0:2]  g3_code;

    assign is_group1 = instruction[0:3] == op_group1[0:3];
    assign is_group3 = (instruction & op_group3_mask) == op_group3_mask;

    // CLA and CLL act before CMA and CML
    assign f1_ac   = (instruction[4] ? 12'o0000 : ac) ^ {12{instruction[6]}};
    assign f1_link = (instruction[5] ? 1'b0 : link) ^ instruction[7];

    assign inc_sum = {link, ac} + 13'd1;
    assign g3_code = {instruction[4], instruction[5], instruction[7]};   // cla mqa mql

    always_comb
    begin
        upd.wr_ac     = 1'b0;
        upd.wr_link   = 1'b0;
        upd.wr_mq     = 1'b0;
        upd.ac_next   = ac;
        upd.link_next = link;
        upd.mq_next   = mq;
        case (phase)
            ph_f1:
                if (is_group1)
                begin
                    upd.wr_ac     = 1'b1;
                    upd.wr_link   = 1'b1;
                    upd.ac_next   = f1_ac;
                    upd.link_next = f1_link;
                end
                else if (is_group3 && g3_code != 3'b000)
                begin
                    upd.wr_ac = 1'b1;
                    upd.wr_mq = 1'b1;
                    case (g3_code)
                        3'b001: {upd.ac_next, upd.mq_next} = {12'o0000, ac};    // MQL
                        3'b010: upd.ac_next = ac | mq;                          // MQA
                        3'b011: {upd.ac_next, upd.mq_next} = {mq, ac};          // SWP
                        3'b100: upd.ac_next = 12'o0000;                         // CLA
                        3'b101: {upd.ac_next, upd.mq_next} = {12'o0000, 12'o0000}; // CAM
                        3'b110: upd.ac_next = mq;                               // ACL
                        default: {upd.ac_next, upd.mq_next} = {mq, 12'o0000};   // CLA SWP
                    endcase
                end
            ph_f2:
                if (is_group1 && instruction[11])   // IAC carries into link
                begin
                    upd.wr_ac   = 1'b1;
                    upd.wr_link = 1'b1;
                    {upd.link_next, upd.ac_next} = inc_sum;
                end
            ph_f3:
                if (is_group1)
                begin
                    upd.wr_ac   = 1'b1;
                    upd.wr_link = 1'b1;
                    case (instruction[8:10])
                        3'b001: upd.ac_next = {ac[6:11], ac[0:5]};   // byte swap
                        3'b010: {upd.link_next, upd.ac_next} = {ac, link};
                        3'b011: {upd.link_next, upd.ac_next} = {ac[1:11], link, ac[0]};
                        3'b100: {upd.link_next, upd.ac_next} = {ac[11], link, ac[0:10]};
                        3'b101: {upd.link_next, upd.ac_next} = {ac[10:11], link, ac[0:9]};
                        default: ;   // no rotate, values unchanged
                    endcase
                end
            default: ;
        endcase
    end

endmodule

/* design/mem_ref_unit.sv */
/*
 * AND, TAD and the DCA clear.
 * The operand is captured in ph_e1 and used in ph_e2, so mdout
 * only has to be valid during ph_e1.
 */
`timescale 1ns/1ps

module mem_ref_unit import pdp8_ac_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  phase_t             phase,
    input  word_t              instruction,
    input  word_t              mdout,
    input  word_t              ac,
    input  logic               link,
    ac_update_if.source        upd
);

    word_t      operand;
    logic [0:2] opcode;

    assign opcode = instruction[0:2];

    always_ff @(posedge clk)
    begin
        if (reset)
            operand <= 12'o0000;
        else if (phase == ph_e1)
            operand <= mdout;   // memory read data
    end

    assign upd.wr_ac   = (phase == ph_e2 && (opcode == opc_and || opcode == opc_tad)) ||
                         (phase == ph_e3 && opcode == opc_dca);
    assign upd.wr_link = phase == ph_e2 && opcode == opc_tad;
    assign upd.wr_mq   = 1'b0;
    assign upd.mq_next = 12'o0000;

    always_comb
    begin
        {upd.link_next, upd.ac_next} = {link, ac} + {1'b0, operand};   // TAD
        if (phase == ph_e3)
            upd.ac_next = 12'o0000;   // DCA, after the store
        else if (opcode == opc_and)
            upd.ac_next = ac & operand;
    end

endmodule

/* design/eae_multiplier.sv */
/*
 * EAE mode A multiply, one multiplier bit per ph_eae_step cycle.
 * The sequencer must hold ph_eae_step and a steady mdout while
 * eae_loop is high. Result is ac:mq = mq * mdout + ac, link cleared.
 */
`timescale 1ns/1ps

module eae_multiplier import pdp8_ac_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  phase_t             phase,
    input  word_t              instruction,
    input  word_t              mdout,
    input  word_t              ac,
    input  word_t              mq,
    output logic               eae_loop,
    ac_update_if.source        upd
);

    step_t       step_count;
    logic        is_mul;
    logic        start_en;
    logic        step_en;
    logic [0:12] add_sum;
    logic [0:23] shifted;

    assign is_mul   = {instruction[0:3], instruction[8:11]} == {op_mul[0:3], op_mul[8:11]};
    assign start_en = phase == ph_eae_start && is_mul;
    assign step_en  = phase == ph_eae_step && eae_loop;

    // add when the low multiplier bit is set, then shift carry:ac:mq right
    assign add_sum = mq[11] ? {1'b0, ac} + {1'b0, mdout} : {1'b0, ac};
    assign shifted = {add_sum, mq[0:10]};

    assign upd.wr_ac     = step_en;
    assign upd.wr_mq     = step_en;
    assign upd.wr_link   = start_en;
    assign upd.ac_next   = shifted[0:11];
    assign upd.mq_next   = shifted[12:23];
    assign upd.link_next = 1'b0;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            step_count <= '0;
            eae_loop   <= 1'b0;
        end
        else if (start_en)
        begin
            step_count <= step_t'(mul_steps);
            eae_loop   <= 1'b1;
        end
        else if (step_en)
        begin
            step_count <= step_count - step_t'(1);
            if (step_count == step_t'(1))
                eae_loop <= 1'b0;   // last step done
        end
    end

endmodule

/* design/ac_register_file.sv */
/*
 * AC, link and MQ with reset, console clear and unit writes.
 * Units are never active in the same phase. If two strobe anyway,
 * operate wins over memory reference, which wins over multiply.
 */
`timescale 1ns/1ps

module ac_register_file import pdp8_ac_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  phase_t             phase,
    input  logic               clear,
    ac_update_if.sink          op_upd,
    ac_update_if.sink          mem_upd,
    ac_update_if.sink          eae_upd,
    output word_t              ac,
    output word_t              mq,
    output logic               link
);

    always_ff @(posedge clk)
    begin
        if (reset || (phase == ph_h2 && clear))   // console clear acts like reset
        begin
            ac   <= 12'o0000;
            mq   <= 12'o0000;
            link <= 1'b0;
        end
        else
        begin
            if (op_upd.wr_ac)
                ac <= op_upd.ac_next;
            else if (mem_upd.wr_ac)
                ac <= mem_upd.ac_next;
            else if (eae_upd.wr_ac)
                ac <= eae_upd.ac_next;

            if (op_upd.wr_link)
                link <= op_upd.link_next;
            else if (mem_upd.wr_link)
                link <= mem_upd.link_next;
            else if (eae_upd.wr_link)
                link <= eae_upd.link_next;

            if (op_upd.wr_mq)
                mq <= op_upd.mq_next;
            else if (mem_upd.wr_mq)
                mq <= mem_upd.mq_next;
            else if (eae_upd.wr_mq)
                mq <= eae_upd.mq_next;
        end
    end

endmodule

/* design/pdp8_ac.sv */
/*
 * PDP-8/e accumulator datapath top level.
 * phase is obeyed every cycle, outputs change one cycle later.
 * No IOT, switch register, EAE mode B, divide or shifts.
 */
`timescale 1ns/1ps

module pdp8_ac import pdp8_ac_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  phase_t  phase,
    input  word_t   instruction,
    input  word_t   mdout,
    input  logic    clear,
    output word_t   ac,
    output word_t   mq,
    output logic    link,
    output logic    eae_loop
);

    ac_update_if op_upd ();
    ac_update_if mem_upd ();
    ac_update_if eae_upd ();

    operate_unit u_operate (
        .phase       (phase),
        .instruction (instruction),
        .ac          (ac),
        .link        (link),
        .mq          (mq),
        .upd         (op_upd.source)
    );

    mem_ref_unit u_mem_ref (
        .clk         (clk),
        .reset       (reset),
        .phase       (phase),
        .instruction (instruction),
        .mdout       (mdout),
        .ac          (ac),
        .link        (link),
        .upd         (mem_upd.source)
    );

    eae_multiplier u_eae_mul (
        .clk         (clk),
        .reset       (reset),
        .phase       (phase),
        .instruction (instruction),
        .mdout       (mdout),
        .ac          (ac),
        .mq          (mq),
        .eae_loop    (eae_loop),
        .upd         (eae_upd.source)
    );

    ac_register_file u_regs (
        .clk     (clk),
        .reset   (reset),
        .phase   (phase),
        .clear   (clear),
        .op_upd  (op_upd.sink),
        .mem_upd (mem_upd.sink),
        .eae_upd (eae_upd.sink),
        .ac      (ac),
        .mq      (mq),
        .link    (link)
    );

endmodule

/* testbench/ac_ref_model.svh */
/*
 * Reference models for the accumulator datapath checks.
 * Words use PDP-8 numbering with bit 0 the most significant.
 * Included inside the testbench module, which imports the package.
 */
`ifndef ac_ref_model_svh
`define ac_ref_model_svh

// full group 1 pass through f1, f2 and f3 giving link:ac
function automatic logic [0:12] ref_group1(input word_t ins, input word_t a, input logic l);
    logic [0:12] v;
    v = {ins[5] ? 1'b0 : l, ins[4] ? 12'o0000 : a};
    if (ins[6])
        v[1:12] = ~v[1:12];
    if (ins[7])
        v[0] = ~v[0];
    if (ins[11])
        v = v + 13'd1;
    if (ins[8:10] == 3'b001)
        v = {v[0], v[7:12], v[1:6]};   // byte swap leaves link alone
    else if (ins[8:10] >= 3'b010 && ins[8:10] <= 3'b101)
    begin
        // bit 9 picks left, bit 10 picks twice
        for (int k = 0; k <= int'(ins[10]); k++)
            v = ins[9] ? {v[1:12], v[0]} : {v[12], v[0:11]};
    end
    return v;
endfunction

// CLA first and then MQA and MQL on the cleared ac giving ac:mq
function automatic logic [0:23] ref_group3(input word_t ins, input word_t a, input word_t m);
    word_t t;
    t = ins[4] ? 12'o0000 : a;
    return {(ins[7] ? 12'o0000 : t) | (ins[5] ? m : 12'o0000), ins[7] ? t : m};
endfunction

// returns link:ac after the memory reference
function automatic logic [0:12] ref_memref(input logic [0:2] opc, input word_t a, input logic l,
                                           input word_t operand);
    logic [0:12] sum;
    sum = {1'b0, a} + {1'b0, operand};
    case (opc)
        opc_and: return {l, a & operand};
        opc_tad: return {l ^ sum[0], sum[1:12]};   // carry out complements link
        opc_dca: return {l, 12'o0000};
        default: return {l, a};
    endcase
endfunction

function automatic logic [23:0] ref_mul(input word_t m, input word_t md, input word_t a);
    return 24'(m) * 24'(md) + 24'(a);
endfunction

`endif

/* testbench/tb_pdp8_ac.sv */
/*
 * Testbench for the accumulator datapath top level.
 * Register state is set up through the DUT itself (console clear,
 * TAD and MQL), so every test assumes those paths work.
 * Inputs change and outputs are read 1 ns after the rising edge.
 */
`timescale 1ns/1ps

module tb_pdp8_ac import pdp8_ac_pkg::*;;

    `include "ac_ref_model.svh"

    // reset plus iterations x cycles per iteration for each test plus margin
    localparam int cycle_limit = 9 + 200 * 11 + 8 * 9 + 100 * 11 + 50 * 22 + 11 + 200;

    logic        clk;
    logic        reset;
    logic        clear;
    logic        link;
    logic        eae_loop;
    phase_t      phase;
    word_t       instruction;
    word_t       mdout;
    word_t       ac;
    word_t       mq;
    logic [31:0] rng_state;
    int          pass_count;
    int          fail_count;
    int          test_errors;
    int          cycle_count;

    pdp8_ac dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout, the run did not end within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic drive(input phase_t ph, input word_t ins, input word_t md, input logic clr);
        @(posedge clk);
        #1;
        phase       = ph;
        instruction = ins;
        mdout       = md;
        clear       = clr;
    endtask

    // always 7 cycles
    task automatic load_state(input word_t a, input logic l, input word_t m);
        drive(ph_h2, 12'o0000, 12'o0000, 1'b1);
        drive(ph_e1, 12'o1000, m, 1'b0);          // TAD m
        drive(ph_e2, 12'o1000, m, 1'b0);
        drive(ph_f1, 12'o7421, 12'o0000, 1'b0);   // MQL
        drive(ph_e1, 12'o1000, a, 1'b0);          // TAD a
        drive(ph_e2, 12'o1000, a, 1'b0);
        drive(ph_f1, l ? 12'o7020 : 12'o7000, 12'o0000, 1'b0);   // CML or NOP
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("FAILED %s expected %o actual %o", name, expected, actual);
            fail_count++;
            test_errors++;
        end
        else
            pass_count++;
    endtask

    task automatic end_test(input string name, input int checks);
        $display("%s done, %0d checks, %0d errors", name, checks, test_errors);
        test_errors = 0;
    endtask

    initial
    begin
        logic [31:0] r;
        logic [31:0] s;
        word_t       a;
        word_t       m;
        word_t       md;
        word_t       ins;
        logic        l;
        int          steps;
        rng_state   = 32'hf4e3_8ea8;
        pass_count  = 0;
        fail_count  = 0;
        test_errors = 0;
        cycle_count = 0;
        clk         = 1'b0;
        reset       = 1'b1;
        clear       = 1'b0;
        phase       = ph_idle;
        instruction = 12'o0000;
        mdout       = 12'o0000;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        drive(ph_idle, 12'o0000, 12'o0000, 1'b0);
        check_value("reset", 32'd0, {6'd0, eae_loop, link, ac, mq});
        end_test("reset", 1);

        for (int i = 0; i < 200; i++)
        begin
            r = next_random();
            s = next_random();
            {l, m, a} = r[24:0];
            ins = 12'o7000 | {4'b0000, s[7:0]};
            load_state(a, l, m);
            drive(ph_f1, ins, 12'o0000, 1'b0);
            drive(ph_f2, ins, 12'o0000, 1'b0);
            drive(ph_f3, ins, 12'o0000, 1'b0);
            drive(ph_idle, ins, 12'o0000, 1'b0);
            check_value("group1", {7'd0, ref_group1(ins, a, l), m}, {7'd0, link, ac, mq});
        end
        end_test("group1", 200);

        for (int c = 0; c < 8; c++)
        begin
            r = next_random();
            {l, m, a} = r[24:0];
            ins = 12'o7401 | {4'b0000, c[2], c[1], 1'b0, c[0], 4'b0000};   // cla mqa mql
            load_state(a, l, m);
            drive(ph_f1, ins, 12'o0000, 1'b0);
            drive(ph_idle, ins, 12'o0000, 1'b0);
            check_value("group3", {7'd0, l, ref_group3(ins, a, m)}, {7'd0, link, ac, mq});
        end
        end_test("group3", 8);

        for (int i = 0; i < 100; i++)
        begin
            r = next_random();
            s = next_random();
            {l, m, a} = r[24:0];
            md = s[27:16];
            case (s % 3)
                0: ins = {opc_and, s[11:3]};
                1: ins = {opc_tad, s[11:3]};
                default: ins = {opc_dca, s[11:3]};
            endcase
            load_state(a, l, m);
            drive(ph_e1, ins, md, 1'b0);
            drive(ph_e2, ins, ~md, 1'b0);   // operand must come from the ph_e1 latch
            drive(ph_e3, ins, ~md, 1'b0);
            drive(ph_idle, ins, ~md, 1'b0);
            check_value("memref", {7'd0, ref_memref(ins[0:2], a, l, md), m},
                        {7'd0, link, ac, mq});
        end
        end_test("memref", 100);

        for (int i = 0; i < 50; i++)
        begin
            r = next_random();
            s = next_random();
            {l, m, a} = r[24:0];
            md = s[11:0];
            load_state(a, l, m);
            drive(ph_eae_start, 12'o7405, md, 1'b0);
            steps = 0;
            drive(ph_eae_step, 12'o7405, md, 1'b0);
            while (eae_loop)   // one step per cycle while high
            begin
                steps++;
                drive(ph_eae_step, 12'o7405, md, 1'b0);
            end
            drive(ph_idle, 12'o7405, md, 1'b0);
            check_value("mul steps", 32'd12, 32'(steps));
            check_value("mul product", {8'd0, ref_mul(m, md, a)}, {8'd0, ac, mq});
            check_value("mul link", 32'd0, {31'd0, link});
        end
        end_test("mul", 150);

        r = next_random();
        {l, m, a} = r[24:0];
        load_state(a, l, m);
        drive(ph_h2, 12'o0000, 12'o0000, 1'b0);
        drive(ph_idle, 12'o0000, 12'o0000, 1'b0);
        check_value("console hold", {7'd0, l, a, m}, {7'd0, link, ac, mq});
        drive(ph_h2, 12'o0000, 12'o0000, 1'b1);
        drive(ph_idle, 12'o0000, 12'o0000, 1'b0);
        check_value("console clear", 32'd0, {7'd0, link, ac, mq});
        end_test("console", 2);

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+testbench
design/pdp8_ac_pkg.sv
design/ac_update_if.sv
design/operate_unit.sv
design/mem_ref_unit.sv
design/eae_multiplier.sv
design/ac_register_file.sv
design/pdp8_ac.sv
testbench/tb_pdp8_ac.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then search the log for the failure line
verilator --binary --timing -f vlog.f --top-module tb_pdp8_ac -o tb_pdp8_ac &&
    ./obj_dir/tb_pdp8_ac > sim.log 2>&1 ||
    { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
